/* rtl/gfx_macros.svh */
// Graphics constants shared by the display blocks
// 640x480 raster timing, 16:9 letterbox rows and framebuffer geometry

`ifndef GFX_MACROS_SVH
`define GFX_MACROS_SVH

// horizontal timing in pixels
`define GFX_H_ACTIVE      640
`define GFX_H_SYNC_START  656
`define GFX_H_SYNC_END    751
`define GFX_H_TOTAL       800

// vertical timing in lines
`define GFX_V_ACTIVE      480
`define GFX_V_SYNC_START  490
`define GFX_V_SYNC_END    491
`define GFX_V_TOTAL       525

// letterbox screen rows, inclusive
`define GFX_LB_TOP        60
`define GFX_LB_BOTTOM     419

// framebuffer geometry and display scale
`define GFX_FB_WIDTH      320
`define GFX_FB_HEIGHT     180
`define GFX_FB_SCALE      2

`endif

/* rtl/gfx_pkg.sv */
// Graphics types
// coordinates, palette indices, colour channels and sequencer states

package gfx_pkg;

    // screen or framebuffer coordinate, signed so line deltas work directly
    typedef logic signed [15:0] coord_t;

    // palette index stored per framebuffer pixel
    typedef logic [3:0] cidx_t;

    // one colour channel of the display output
    typedef logic [3:0] chan_t;

    // outline sequencer states
    typedef enum logic [2:0] {
        seq_idle,   // waiting for first vertical blank
        seq_clear,  // writing black over the framebuffer
        seq_init,   // loading the next line
        seq_draw,   // line drawer running
        seq_done    // all lines written
    } seq_state_t;

endpackage

/* rtl/display_timing.sv */
// Display timing generator
// scans the 800x525 raster and decodes sync, data enable and frame start

`timescale 1ns/1ps

`include "gfx_macros.svh"

module display_timing (
    input  logic            clk_pix,
    input  logic            arst_n,
    output gfx_pkg::coord_t sx,      // horizontal position
    output gfx_pkg::coord_t sy,      // vertical position
    output logic            hsync,   // low during sync
    output logic            vsync,   // low during sync
    output logic            de,      // active area
    output logic            frame    // start of vertical blank
);

    logic line_end;  // last pixel of a line
    logic frame_end; // last line of a frame

    assign line_end  = (sx == gfx_pkg::coord_t'(`GFX_H_TOTAL - 1));
    assign frame_end = (sy == gfx_pkg::coord_t'(`GFX_V_TOTAL - 1));

    // pixel and line counters
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            sx <= '0;
            sy <= '0;
        end else if (line_end) begin
            sx <= '0;
            sy <= frame_end ? '0 : sy + 16'sd1;  // wrap at end of frame
        end else begin
            sx <= sx + 16'sd1;
        end
    end

    // sync pulses are active low, both ends inclusive
    assign hsync = ~((sx >= `GFX_H_SYNC_START) && (sx <= `GFX_H_SYNC_END));
    assign vsync = ~((sy >= `GFX_V_SYNC_START) && (sy <= `GFX_V_SYNC_END));

    assign de = (sx < `GFX_H_ACTIVE) && (sy < `GFX_V_ACTIVE);

    // one pulse per frame, first pixel of the first blank line
    assign frame = (sx == 16'sd0) && (sy == gfx_pkg::coord_t'(`GFX_V_ACTIVE));

endmodule

/* rtl/line_drawer.sv */
// Bresenham line drawer
// walks from (x0,y0) to (x1,y1) in any octant, one pixel per enabled cycle

`timescale 1ns/1ps

module line_drawer (
    input  logic            clk_pix,
    input  logic            arst_n,
    input  logic            start,    // begin a new line
    input  logic            oe,       // output enable, hold when low
    input  gfx_pkg::coord_t x0,
    input  gfx_pkg::coord_t y0,
    input  gfx_pkg::coord_t x1,
    input  gfx_pkg::coord_t y1,
    output gfx_pkg::coord_t x,
    output gfx_pkg::coord_t y,
    output logic            drawing,  // x and y hold a new pixel
    output logic            done      // pulse after the last pixel
);

    typedef enum logic {
        ld_idle,
        ld_draw
    } ld_state_t;

    ld_state_t state;

    logic signed [16:0] dx_in;   // absolute x delta of the inputs
    logic signed [16:0] dy_in;   // negated absolute y delta of the inputs
    logic signed [16:0] dx;
    logic signed [16:0] dy;
    logic signed [17:0] err;
    logic signed [18:0] e2;
    gfx_pkg::coord_t    xe;      // end point latched at start
    gfx_pkg::coord_t    ye;
    logic               right;   // step direction in x
    logic               down;    // step direction in y
    logic               mv_x;
    logic               mv_y;
    logic               at_end;
    logic               step;

    assign dx_in = (x1 > x0) ? 17'(x1) - 17'(x0) : 17'(x0) - 17'(x1);
    assign dy_in = (y1 > y0) ? 17'(y0) - 17'(y1) : 17'(y1) - 17'(y0);

    // error doubled, then compared against each delta
    assign e2   = 19'(err) <<< 1;
    assign mv_x = (e2 >= 19'(dy));
    assign mv_y = (e2 <= 19'(dx));

    assign at_end  = (x == xe) && (y == ye);
    assign drawing = (state == ld_draw) && oe;
    assign step    = drawing && !at_end;

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            state <= ld_idle;
            done  <= 1'b0;
        end else begin
            done <= 1'b0;
            case (state)
                ld_draw: begin
                    if (oe && at_end) begin  // last pixel goes out this cycle
                        state <= ld_idle;
                        done  <= 1'b1;
                    end
                end
                default: begin
                    if (start) state <= ld_draw;
                end
            endcase
        end
    end

    // position, deltas and error term
    always_ff @(posedge clk_pix) begin
        if (state == ld_idle && start) begin
            x     <= x0;
            y     <= y0;
            xe    <= x1;
            ye    <= y1;
            right <= (x0 < x1);
            down  <= (y0 < y1);
            dx    <= dx_in;
            dy    <= dy_in;
            err   <= 18'(dx_in) + 18'(dy_in);
        end else if (step) begin
            if (mv_x) x <= right ? x + 16'sd1 : x - 16'sd1;
            if (mv_y) y <= down ? y + 16'sd1 : y - 16'sd1;
            err <= err + (mv_x ? 18'(dy) : 18'sd0) + (mv_y ? 18'(dx) : 18'sd0);
        end
    end

endmodule

/* rtl/frame_store.sv */
// Framebuffer with palette
// 320x180 colour indices shown at 2x scale in the letterbox, one-cycle read

`timescale 1ns/1ps

`include "gfx_macros.svh"

module frame_store (
    input  logic            clk_pix,
    input  logic            arst_n,
    input  logic            we,      // write strobe
    input  gfx_pkg::coord_t wx,      // framebuffer write column
    input  gfx_pkg::coord_t wy,      // framebuffer write row
    input  gfx_pkg::cidx_t  wcidx,   // colour index to write
    input  gfx_pkg::coord_t sx,      // screen scan position
    input  gfx_pkg::coord_t sy,
    output logic            busy,    // display reading the array
    output gfx_pkg::chan_t  red,
    output gfx_pkg::chan_t  green,
    output gfx_pkg::chan_t  blue
);

    gfx_pkg::cidx_t fb_mem [`GFX_FB_WIDTH * `GFX_FB_HEIGHT];

    logic [15:0] rrow;   // framebuffer row under the beam
    logic [15:0] rcol;   // framebuffer column under the beam
    logic [15:0] raddr;
    logic [15:0] waddr;

    // 16-colour table, packed as {r,g,b}
    function automatic logic [11:0] palette(input gfx_pkg::cidx_t idx);
        logic [11:0] rgb;
        case (idx)
            4'h0:    rgb = 12'h000;  // black
            4'h1:    rgb = 12'h125;
            4'h2:    rgb = 12'h725;
            4'h3:    rgb = 12'h085;
            4'h4:    rgb = 12'ha53;
            4'h5:    rgb = 12'h555;
            4'h6:    rgb = 12'hccc;
            4'h7:    rgb = 12'hfff;  // white
            4'h8:    rgb = 12'hf00;  // red
            4'h9:    rgb = 12'hfa0;
            4'ha:    rgb = 12'hff0;  // yellow
            4'hb:    rgb = 12'h0f0;  // green
            4'hc:    rgb = 12'h00f;  // blue
            4'hd:    rgb = 12'h879;
            4'he:    rgb = 12'hf7a;
            default: rgb = 12'hfca;
        endcase
        return rgb;
    endfunction

    // letterbox rows lie inside the active lines, so this covers both limits
    assign busy = (sx < `GFX_H_ACTIVE) && (sy >= `GFX_LB_TOP) && (sy <= `GFX_LB_BOTTOM);

    assign rrow  = 16'((sy - `GFX_LB_TOP) / `GFX_FB_SCALE);
    assign rcol  = 16'(sx / `GFX_FB_SCALE);
    assign raddr = 16'(rrow * `GFX_FB_WIDTH + rcol);
    assign waddr = 16'(wy * `GFX_FB_WIDTH + wx);

    always_ff @(posedge clk_pix) begin
        if (we) fb_mem[waddr] <= wcidx;
    end

    // read and palette lookup, black outside the letterbox
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            {red, green, blue} <= '0;
        end else if (busy) begin
            {red, green, blue} <= palette(fb_mem[raddr]);
        end else begin
            {red, green, blue} <= '0;
        end
    end

endmodule

/* rtl/outline_sequencer.sv */
// Outline sequencer
// clears the framebuffer after the first frame pulse, then draws four edges

`timescale 1ns/1ps

`include "gfx_macros.svh"

module outline_sequencer (
    input  logic            clk_pix,
    input  logic            arst_n,
    input  logic            frame,      // start of vertical blank
    input  logic            busy,       // framebuffer in use by display
    input  logic            drawing,    // drawer pixel valid
    input  logic            done,       // drawer finished a line
    input  gfx_pkg::coord_t px,         // drawer pixel
    input  gfx_pkg::coord_t py,
    output logic            start,      // drawer start pulse
    output gfx_pkg::coord_t x0,
    output gfx_pkg::coord_t y0,
    output gfx_pkg::coord_t x1,
    output gfx_pkg::coord_t y1,
    output logic            we,
    output gfx_pkg::coord_t wx,
    output gfx_pkg::coord_t wy,
    output gfx_pkg::cidx_t  wcidx,
    output logic            draw_done   // sticky once all lines are in
);

    localparam gfx_pkg::coord_t x_max = gfx_pkg::coord_t'(`GFX_FB_WIDTH - 1);
    localparam gfx_pkg::coord_t y_max = gfx_pkg::coord_t'(`GFX_FB_HEIGHT - 1);

    gfx_pkg::seq_state_t state;
    gfx_pkg::coord_t     cx;          // clear position
    gfx_pkg::coord_t     cy;
    gfx_pkg::cidx_t      line_cidx;   // colour of the current line
    logic [1:0]          line_id;
    logic                clear_wr;

    assign clear_wr = (state == gfx_pkg::seq_clear) && !busy;

    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            state     <= gfx_pkg::seq_idle;
            cx        <= '0;
            cy        <= '0;
            line_id   <= '0;
            start     <= 1'b0;
            draw_done <= 1'b0;
        end else begin
            start <= 1'b0;
            case (state)
                gfx_pkg::seq_clear: begin
                    if (clear_wr) begin
                        if (cx == x_max && cy == y_max) begin
                            state   <= gfx_pkg::seq_init;
                            line_id <= '0;
                        end else if (cx == x_max) begin  // next row
                            cx <= '0;
                            cy <= cy + 16'sd1;
                        end else begin
                            cx <= cx + 16'sd1;
                        end
                    end
                end
                gfx_pkg::seq_init: begin
                    start <= 1'b1;
                    state <= gfx_pkg::seq_draw;
                end
                gfx_pkg::seq_draw: begin
                    if (done) begin
                        if (line_id == 2'd3) begin
                            state     <= gfx_pkg::seq_done;
                            draw_done <= 1'b1;
                        end else begin
                            line_id <= line_id + 2'd1;
                            state   <= gfx_pkg::seq_init;
                        end
                    end
                end
                gfx_pkg::seq_done: state <= gfx_pkg::seq_done;
                default: begin  // idle
                    if (frame) begin
                        state <= gfx_pkg::seq_clear;
                        cx    <= '0;
                        cy    <= '0;
                    end
                end
            endcase
        end
    end

    // endpoints and colour for each edge, held while the line runs
    always_ff @(posedge clk_pix) begin
        if (state == gfx_pkg::seq_init) begin
            case (line_id)
                2'd0: begin  // top
                    line_cidx <= 4'h8;
                    x0 <= '0;
                    y0 <= '0;
                    x1 <= x_max;
                    y1 <= '0;
                end
                2'd1: begin  // right
                    line_cidx <= 4'ha;
                    x0 <= x_max;
                    y0 <= '0;
                    x1 <= x_max;
                    y1 <= y_max;
                end
                2'd2: begin  // bottom
                    line_cidx <= 4'hb;
                    x0 <= x_max;
                    y0 <= y_max;
                    x1 <= '0;
                    y1 <= y_max;
                end
                default: begin  // left
                    line_cidx <= 4'hc;
                    x0 <= '0;
                    y0 <= y_max;
                    x1 <= '0;
                    y1 <= '0;
                end
            endcase
        end
    end

    // framebuffer write port
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) we <= 1'b0;
        else we <= clear_wr || drawing;
    end

    always_ff @(posedge clk_pix) begin
        if (state == gfx_pkg::seq_clear) begin
            wx    <= cx;
            wy    <= cy;
            wcidx <= '0;  // black
        end else begin
            wx    <= px;
            wy    <= py;
            wcidx <= line_cidx;
        end
    end

endmodule

/* rtl/latency_check_top.sv */
// Latency check top level
// draws a coloured outline into the framebuffer and scans it out

`timescale 1ns/1ps

module latency_check_top (
    input  logic           clk_pix,
    input  logic           arst_n,
    output logic           dvi_hsync,
    output logic           dvi_vsync,
    output logic           dvi_de,
    output gfx_pkg::chan_t dvi_r,
    output gfx_pkg::chan_t dvi_g,
    output gfx_pkg::chan_t dvi_b,
    output logic           draw_done
);

    gfx_pkg::coord_t sx;
    gfx_pkg::coord_t sy;
    logic            hsync;
    logic            vsync;
    logic            de;
    logic            frame;
    logic            fb_busy;
    gfx_pkg::chan_t  fb_red;
    gfx_pkg::chan_t  fb_green;
    gfx_pkg::chan_t  fb_blue;
    logic            fb_we;
    gfx_pkg::coord_t fb_x;
    gfx_pkg::coord_t fb_y;
    gfx_pkg::cidx_t  fb_cidx;
    logic            line_start;
    gfx_pkg::coord_t lx0;
    gfx_pkg::coord_t ly0;
    gfx_pkg::coord_t lx1;
    gfx_pkg::coord_t ly1;
    gfx_pkg::coord_t line_x;
    gfx_pkg::coord_t line_y;
    logic            drawing;
    logic            line_done;
    logic            hsync_p1;   // sync delayed to match the read
    logic            vsync_p1;
    logic            de_p1;

    display_timing u_timing (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .sx      (sx),
        .sy      (sy),
        .hsync   (hsync),
        .vsync   (vsync),
        .de      (de),
        .frame   (frame)
    );

    frame_store u_fb (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .we      (fb_we),
        .wx      (fb_x),
        .wy      (fb_y),
        .wcidx   (fb_cidx),
        .sx      (sx),
        .sy      (sy),
        .busy    (fb_busy),
        .red     (fb_red),
        .green   (fb_green),
        .blue    (fb_blue)
    );

    outline_sequencer u_seq (
        .clk_pix   (clk_pix),
        .arst_n    (arst_n),
        .frame     (frame),
        .busy      (fb_busy),
        .drawing   (drawing),
        .done      (line_done),
        .px        (line_x),
        .py        (line_y),
        .start     (line_start),
        .x0        (lx0),
        .y0        (ly0),
        .x1        (lx1),
        .y1        (ly1),
        .we        (fb_we),
        .wx        (fb_x),
        .wy        (fb_y),
        .wcidx     (fb_cidx),
        .draw_done (draw_done)
    );

    line_drawer u_line (
        .clk_pix (clk_pix),
        .arst_n  (arst_n),
        .start   (line_start),
        .oe      (!fb_busy),   // only draw while the display is off the array
        .x0      (lx0),
        .y0      (ly0),
        .x1      (lx1),
        .y1      (ly1),
        .x       (line_x),
        .y       (line_y),
        .drawing (drawing),
        .done    (line_done)
    );

    // one-cycle delay for the framebuffer read, then the output register
    always_ff @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            hsync_p1  <= 1'b1;
            vsync_p1  <= 1'b1;
            de_p1     <= 1'b0;
            dvi_hsync <= 1'b1;
            dvi_vsync <= 1'b1;
            dvi_de    <= 1'b0;
            dvi_r     <= '0;
            dvi_g     <= '0;
            dvi_b     <= '0;
        end else begin
            hsync_p1  <= hsync;
            vsync_p1  <= vsync;
            de_p1     <= de;
            dvi_hsync <= hsync_p1;
            dvi_vsync <= vsync_p1;
            dvi_de    <= de_p1;
            dvi_r     <= fb_red;
            dvi_g     <= fb_green;
            dvi_b     <= fb_blue;
        end
    end

endmodule

/* sim/tb_clock_gen.sv */
// Testbench clock and reset source
// free-running pixel clock, reset held low for a fixed number of cycles

`timescale 1ns/1ps

module tb_clock_gen #(
    parameter int period_ns    = 10,
    parameter int reset_cycles = 10
) (
    output logic clk_pix,
    output logic arst_n
);

    initial begin
        clk_pix = 1'b0;
        forever #(period_ns / 2) clk_pix = ~clk_pix;
    end

    initial begin
        arst_n = 1'b0;
        repeat (reset_cycles) @(posedge clk_pix);
        #1 arst_n = 1'b1;  // release just after an edge
    end

endmodule

/* sim/tb_latency_check.sv */
// Testbench for the outline drawing display top level
// checks raster timing, letterbox blanking, completion and the final picture

`timescale 1ns/1ps

`include "gfx_macros.svh"

module tb_latency_check;

    localparam int clk_period_ns = 10;
    localparam int frame_cycles  = `GFX_H_TOTAL * `GFX_V_TOTAL;
    localparam int hs_len        = `GFX_H_SYNC_END - `GFX_H_SYNC_START + 1;
    localparam int vs_len        = (`GFX_V_SYNC_END - `GFX_V_SYNC_START + 1) * `GFX_H_TOTAL;
    localparam int hs_to_de      = `GFX_H_TOTAL - `GFX_H_SYNC_START;
    localparam int vs_to_de      = (`GFX_V_TOTAL - `GFX_V_SYNC_START) * `GFX_H_TOTAL;
    localparam int lb_pixels     = (`GFX_LB_BOTTOM - `GFX_LB_TOP + 1) * `GFX_H_ACTIVE;
    localparam int watchdog_ns   = 6 * frame_cycles * clk_period_ns;
    localparam int num_tests     = 5;

    logic           clk_pix;
    logic           arst_n;
    logic           dvi_hsync;
    logic           dvi_vsync;
    logic           dvi_de;
    gfx_pkg::chan_t dvi_r;
    gfx_pkg::chan_t dvi_g;
    gfx_pkg::chan_t dvi_b;
    logic           draw_done;

    logic        hs_q;
    logic        vs_q;
    logic        de_q;
    logic        done_q;
    logic        hs_seen;
    int          hs_cnt;     // cycles since last hsync fall
    int          hs_low;
    int          vs_cnt;
    int          vs_low;
    int          line_cnt;   // hsync falls since last vsync fall
    int          de_run;     // column within the active line
    int          de_lines;   // active lines since last vsync fall
    int          vs_falls;
    int          pic_state;  // 0 waiting, 1 checking, 2 finished
    int          pic_pixels;
    int          errs [num_tests];

    logic        hs_fall;
    logic        hs_rise;
    logic        vs_fall;
    logic        vs_rise;
    logic        de_rise;
    logic        de_fall;
    logic        locked;
    logic        in_lb;
    logic        out_lb;
    logic        pic_on;
    int          cur_row;
    int          cur_col;
    logic [11:0] rgb;
    logic [11:0] exp_rgb;

    tb_clock_gen #(.period_ns(clk_period_ns), .reset_cycles(10)) u_clk (
        .clk_pix (clk_pix),
        .arst_n  (arst_n)
    );

    latency_check_top UUT (
        .clk_pix   (clk_pix),
        .arst_n    (arst_n),
        .dvi_hsync (dvi_hsync),
        .dvi_vsync (dvi_vsync),
        .dvi_de    (dvi_de),
        .dvi_r     (dvi_r),
        .dvi_g     (dvi_g),
        .dvi_b     (dvi_b),
        .draw_done (draw_done)
    );

    // expected colour of a screen pixel, later edges overwrite earlier ones
    function automatic logic [11:0] model_rgb(input int row, input int col);
        int fx;
        int fy;
        fx = col / `GFX_FB_SCALE;
        fy = (row - `GFX_LB_TOP) / `GFX_FB_SCALE;
        if (fx == 0) return 12'h00f;                      // left, blue
        if (fy == `GFX_FB_HEIGHT - 1) return 12'h0f0;     // bottom, green
        if (fx == `GFX_FB_WIDTH - 1) return 12'hff0;      // right, yellow
        if (fy == 0) return 12'hf00;                      // top, red
        return 12'h000;
    endfunction

    function automatic string test_label(input int id);
        case (id)
            0:       return "sync_timing";
            1:       return "active_area";
            2:       return "letterbox";
            3:       return "completion";
            default: return "picture";
        endcase
    endfunction

    task automatic log_mismatch(input int id, input string sig, input int got, input int exp);
        errs[id]++;
        $display("FAILED t=%0t %s: got 0x%0h expected 0x%0h", $time, sig, got, exp);
    endtask

    assign hs_fall = hs_q && !dvi_hsync;
    assign hs_rise = !hs_q && dvi_hsync;
    assign vs_fall = vs_q && !dvi_vsync;
    assign vs_rise = !vs_q && dvi_vsync;
    assign de_rise = dvi_de && !de_q;
    assign de_fall = !dvi_de && de_q;
    assign cur_col = de_run;
    assign cur_row = de_rise ? de_lines : de_lines - 1;
    assign locked  = (vs_falls > 0);  // position known after first vsync
    assign in_lb   = dvi_de && locked && (cur_row >= `GFX_LB_TOP) && (cur_row <= `GFX_LB_BOTTOM);
    assign out_lb  = dvi_de && locked && !in_lb;
    assign pic_on  = (pic_state == 1) && in_lb;
    assign rgb     = {dvi_r, dvi_g, dvi_b};
    assign exp_rgb = model_rgb(cur_row, cur_col);

    // screen position and interval tracking from the outputs only
    always @(posedge clk_pix or negedge arst_n) begin
        if (!arst_n) begin
            hs_q       <= 1'b1;
            vs_q       <= 1'b1;
            de_q       <= 1'b0;
            done_q     <= 1'b0;
            hs_seen    <= 1'b0;
            hs_cnt     <= 0;
            hs_low     <= 0;
            vs_cnt     <= 0;
            vs_low     <= 0;
            line_cnt   <= 0;
            de_run     <= 0;
            de_lines   <= 0;
            vs_falls   <= 0;
            pic_state  <= 0;
            pic_pixels <= 0;
        end else begin
            hs_q   <= dvi_hsync;
            vs_q   <= dvi_vsync;
            de_q   <= dvi_de;
            done_q <= draw_done;
            hs_cnt <= hs_fall ? 1 : hs_cnt + 1;
            hs_low <= dvi_hsync ? 0 : hs_low + 1;
            vs_cnt <= vs_fall ? 1 : vs_cnt + 1;
            vs_low <= dvi_vsync ? 0 : vs_low + 1;
            de_run <= dvi_de ? de_run + 1 : 0;
            if (hs_fall) hs_seen <= 1'b1;
            if (pic_on) pic_pixels <= pic_pixels + 1;
            if (vs_fall) begin
                line_cnt <= 0;
                de_lines <= 0;
                if (vs_falls < 15) vs_falls <= vs_falls + 1;
                if (pic_state == 0 && draw_done) pic_state <= 1;  // next frame is complete
                else if (pic_state == 1) pic_state <= 2;
            end else begin
                if (hs_fall) line_cnt <= line_cnt + 1;
                if (de_rise) de_lines <= de_lines + 1;
            end
        end
    end

    // sync timing
    hs_period: assert property (@(posedge clk_pix) disable iff (!arst_n)
        (hs_fall && hs_seen) |-> (hs_cnt == `GFX_H_TOTAL))
        else log_mismatch(0, "hsync period", $sampled(hs_cnt), `GFX_H_TOTAL);
    hs_width: assert property (@(posedge clk_pix) disable iff (!arst_n)
        (hs_rise && hs_seen) |-> (hs_low == hs_len))
        else log_mismatch(0, "hsync low width", $sampled(hs_low), hs_len);
    vs_period: assert property (@(posedge clk_pix) disable iff (!arst_n)
        (vs_fall && locked) |-> (vs_cnt == frame_cycles))
        else log_mismatch(0, "vsync period", $sampled(vs_cnt), frame_cycles);
    vs_lines: assert property (@(posedge clk_pix) disable iff (!arst_n)
        (vs_fall && locked) |-> (line_cnt == `GFX_V_TOTAL))
        else log_mismatch(0, "lines per frame", $sampled(line_cnt), `GFX_V_TOTAL);
    vs_width: assert property (@(posedge clk_pix) disable iff (!arst_n)
        (vs_rise && locked) |-> (vs_low == vs_len))
        else log_mismatch(0, "vsync low width", $sampled(vs_low), vs_len);

    // sync phase against the active area
    hs_phase: assert property (@(posedge clk_pix) disable iff (!arst_n)
        (de_rise && hs_seen) |-> (hs_cnt == hs_to_de))
        else log_mismatch(0, "hsync to dvi_de offset", $sampled(hs_cnt), hs_to_de);
    vs_phase: assert property (@(posedge clk_pix) disable iff (!arst_n)
        (de_rise && locked && de_lines == 0) |-> (vs_cnt == vs_to_de))
        else log_mismatch(0, "vsync to dvi_de offset", $sampled(vs_cnt), vs_to_de);

    // active area
    de_width: assert property (@(posedge clk_pix) disable iff (!arst_n)
        de_fall |-> (de_run == `GFX_H_ACTIVE))
        else log_mismatch(1, "dvi_de run", $sampled(de_run), `GFX_H_ACTIVE);
    de_count: assert property (@(posedge clk_pix) disable iff (!arst_n)
        (vs_fall && locked) |-> (de_lines == `GFX_V_ACTIVE))
        else log_mismatch(1, "active lines", $sampled(de_lines), `GFX_V_ACTIVE);
    blank_black: assert property (@(posedge clk_pix) disable iff (!arst_n)
        !dvi_de |-> (rgb == 12'h000))
        else log_mismatch(1, "dvi_rgb in blanking", $sampled(rgb), 0);

    lb_black: assert property (@(posedge clk_pix) disable iff (!arst_n)
        out_lb |-> (rgb == 12'h000))
        else log_mismatch(2, "dvi_rgb outside letterbox", $sampled(rgb), 0);

    // completion by the third frame, sticky after
    done_by_frame3: assert property (@(posedge clk_pix) disable iff (!arst_n)
        (de_rise && vs_falls >= 2) |-> draw_done)
        else log_mismatch(3, "draw_done", $sampled(draw_done), 1);
    done_sticky: assert property (@(posedge clk_pix) disable iff (!arst_n)
        done_q |-> draw_done)
        else log_mismatch(3, "draw_done", $sampled(draw_done), 1);

    pic_match: assert property (@(posedge clk_pix) disable iff (!arst_n)
        pic_on |-> (rgb == exp_rgb))
        else log_mismatch(4, "dvi_rgb", $sampled(rgb), $sampled(exp_rgb));

    initial begin : main_flow
        int failed_tests;
        int total_errs;
        failed_tests = 0;
        total_errs   = 0;
        for (int i = 0; i < num_tests; i++) errs[i] = 0;
        wait (arst_n === 1'b1);
        @(posedge clk_pix);
        reset_low: assert (draw_done == 1'b0)
            else log_mismatch(3, "draw_done after reset", draw_done, 0);
        wait (pic_state == 2);
        if (pic_pixels != lb_pixels) log_mismatch(4, "picture pixel count", pic_pixels, lb_pixels);
        for (int i = 0; i < num_tests; i++) begin
            total_errs += errs[i];
            if (errs[i] == 0) begin
                $display("PASS   %s", test_label(i));
            end else begin
                failed_tests++;
                $display("FAILED %s: %0d errors", test_label(i), errs[i]);
            end
        end
        $display("tests: %0d run, %0d passed, %0d failed, %0d errors",
                 num_tests, num_tests - failed_tests, failed_tests, total_errs);
        if (failed_tests == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // six frames covers clear, drawing and one checked frame
    initial begin : watchdog
        #(watchdog_ns);
        $display("timeout: the picture check did not finish within six frames");
        $display("Regression failed");
        $finish;
    end

endmodule

/* verilog.f */
+incdir+rtl
rtl/gfx_pkg.sv
rtl/display_timing.sv
rtl/line_drawer.sv
rtl/frame_store.sv
rtl/outline_sequencer.sv
rtl/latency_check_top.sv
sim/tb_clock_gen.sv
sim/tb_latency_check.sv

/* Makefile */
# Verilator build for the outline drawing display testbench

VERILATOR  = verilator
TOP        = tb_latency_check
FILELIST   = verilog.f
OBJ_DIR    = obj_dir
LOG        = sim.log
PASS_MSG   = Regression passed
LINT_FLAGS = --lint-only -Wall --timing
SIM_FLAGS  = --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
